//--- source/ts_pkg.sv
`default_nettype none

package ts_pkg;

	localparam int PACK_BYTE_SIZE = 188;
	localparam int PACK_WORD_SIZE = 47;
	localparam logic [7:0] TS_SYNC_BYTE = 8'h47;

	localparam int PID_SLOTS = 4;
	localparam int DATA_GROUPS = 2;
	localparam int PTS_STEP = 1;
	localparam int PTS_BYTE_FIRST = 24;
	localparam int PTS_BYTES = 5;

	localparam int PID_W = 13;
	localparam int SLOT_W = $clog2(PID_SLOTS);
	localparam int GROUP_W = (DATA_GROUPS > 1) ? $clog2(DATA_GROUPS) : 1;
	localparam int DATA_WORDS = PACK_WORD_SIZE * DATA_GROUPS;
	localparam int WORD_ADDR_W = $clog2(DATA_WORDS);
	localparam int BYTE_ADDR_W = WORD_ADDR_W + 2;
	localparam int INDEX_W = $clog2(PACK_BYTE_SIZE + 1);

	typedef struct packed {
		logic [7:0] data;
		logic       sync;
		logic       valid;
	} ts_byte_t;

	typedef struct packed {
		logic             pts_en;
		logic             change_en;
		logic             match_en;
		logic [PID_W-1:0] pid;
	} pid_entry_t;

	// one per packet start, valid in the cycle hit is set
	typedef struct packed {
		logic               hit;
		logic [SLOT_W-1:0]  slot;
		logic               change_pid;
		logic               pts_en;
		logic [GROUP_W-1:0] group;
		logic [31:0]        pts;
	} match_info_t;

endpackage

`default_nettype wire

//--- source/apb_pkg.sv
`default_nettype none

package apb_pkg;

	localparam int APB_ADDR_W = 16;
	localparam int APB_DATA_W = 32;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DATA_W-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

	localparam logic [APB_ADDR_W-1:0] ADDR_CTRL = 16'h0000;
	localparam logic [APB_ADDR_W-1:0] ADDR_COUNT = 16'h0004;
	localparam logic [APB_ADDR_W-1:0] ADDR_PID_BASE = 16'h0100;
	localparam logic [APB_ADDR_W-1:0] ADDR_DATA_BASE = 16'h1000;

	// slot s: entry at base + 8s, pts at base + 8s + 4
	localparam int PID_STRIDE = 8;

	localparam int CTRL_MATCH_EN_BIT = 0;
	localparam int PID_MATCH_EN_BIT = 16;
	localparam int PID_CHANGE_EN_BIT = 17;
	localparam int PID_PTS_EN_BIT = 18;

endpackage

`default_nettype wire

//--- source/ts_replacer_regs.sv
`default_nettype none

module ts_replacer_regs import ts_pkg::*, apb_pkg::*; (
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire apb_req_t                     apb_req,
	output apb_rsp_t                          apb_rsp,
	output pid_entry_t [PID_SLOTS-1:0]        pid_table,
	output logic [PID_SLOTS-1:0][31:0]        pts_table,
	output logic                              match_enable,
	input  wire match_info_t                  match_info,
	input  wire logic [WORD_ADDR_W-1:0]       rd_addr,
	output logic [31:0]                       rd_word
);

	logic [31:0] data_ram [DATA_WORDS];
	logic [31:0] matched_count;

	logic access;
	logic wr_en;
	logic is_ctrl;
	logic is_count;
	logic is_pid;
	logic is_data;
	logic mapped;
	logic [APB_ADDR_W-1:0] pid_off;
	logic [APB_ADDR_W-1:0] data_off;
	logic [SLOT_W-1:0] pid_slot;
	logic pid_is_pts;
	logic [WORD_ADDR_W-1:0] data_word;
	logic [31:0] pid_word;
	logic [31:0] rd_data;

	assign access = apb_req.psel && apb_req.penable;
	assign wr_en = access && apb_req.pwrite;

	assign pid_off = apb_req.paddr - ADDR_PID_BASE;
	assign data_off = apb_req.paddr - ADDR_DATA_BASE;
	assign pid_slot = pid_off[3 +: SLOT_W];
	assign pid_is_pts = pid_off[2];
	assign data_word = data_off[2 +: WORD_ADDR_W];

	assign is_ctrl = apb_req.paddr == ADDR_CTRL;
	assign is_count = apb_req.paddr == ADDR_COUNT;
	assign is_pid = apb_req.paddr >= ADDR_PID_BASE &&
		pid_off < APB_ADDR_W'(PID_STRIDE * PID_SLOTS) && pid_off[1:0] == 2'b00;
	assign is_data = apb_req.paddr >= ADDR_DATA_BASE &&
		data_off < APB_ADDR_W'(4 * DATA_WORDS) && data_off[1:0] == 2'b00;

	// count is read only, a write there is refused
	assign mapped = is_ctrl || is_pid || is_data || (is_count && !apb_req.pwrite);

	always_comb begin
		pid_word = '0;
		pid_word[PID_W-1:0] = pid_table[pid_slot].pid;
		pid_word[PID_MATCH_EN_BIT] = pid_table[pid_slot].match_en;
		pid_word[PID_CHANGE_EN_BIT] = pid_table[pid_slot].change_en;
		pid_word[PID_PTS_EN_BIT] = pid_table[pid_slot].pts_en;
	end

	always_comb begin
		rd_data = '0;
		if (is_ctrl) begin
			rd_data[CTRL_MATCH_EN_BIT] = match_enable;
		end else if (is_count) begin
			rd_data = matched_count;
		end else if (is_pid && pid_is_pts) begin
			rd_data = pts_table[pid_slot];
		end else if (is_pid) begin
			rd_data = pid_word;
		end else if (is_data) begin
			rd_data = data_ram[data_word];
		end
	end

	assign apb_rsp = '{prdata: rd_data, pready: 1'b1, pslverr: access && !mapped};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			match_enable <= 1'b0;
			matched_count <= '0;
			pid_table <= '0;
			pts_table <= '0;
		end else begin
			if (match_info.hit) begin
				matched_count <= matched_count + 32'd1;
				pts_table[match_info.slot] <= pts_table[match_info.slot] + 32'(PTS_STEP);
			end
			if (wr_en && is_ctrl) begin
				match_enable <= apb_req.pwdata[CTRL_MATCH_EN_BIT];
			end
			if (wr_en && is_pid && !pid_is_pts) begin
				pid_table[pid_slot] <= '{
					pts_en: apb_req.pwdata[PID_PTS_EN_BIT],
					change_en: apb_req.pwdata[PID_CHANGE_EN_BIT],
					match_en: apb_req.pwdata[PID_MATCH_EN_BIT],
					pid: apb_req.pwdata[PID_W-1:0]
				};
			end
			// a register write beats the hit increment on the same edge
			if (wr_en && is_pid && pid_is_pts) begin
				pts_table[pid_slot] <= apb_req.pwdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && is_data) begin
			data_ram[data_word] <= apb_req.pwdata;
		end
	end

	assign rd_word = (rd_addr < WORD_ADDR_W'(DATA_WORDS)) ? data_ram[rd_addr] : '0;

	// every access phase follows a setup phase
	a_apb_setup_access: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable));

endmodule

`default_nettype wire

//--- source/ts_pid_matcher.sv
`default_nettype none

module ts_pid_matcher import ts_pkg::*; (
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire ts_byte_t                     ts_in,
	input  wire pid_entry_t [PID_SLOTS-1:0]   pid_table,
	input  wire logic [PID_SLOTS-1:0][31:0]   pts_table,
	input  wire logic                         match_enable,
	output match_info_t                       match_info,
	output ts_byte_t                          delayed
);

	// stage[2] is the oldest byte
	ts_byte_t [2:0] stage;
	logic [PID_W-1:0] pid_in;
	logic pkt_start;
	logic [PID_SLOTS-1:0] slot_hit;
	logic [SLOT_W-1:0] sel;
	logic [PID_SLOTS-1:0][GROUP_W-1:0] group_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage <= '0;
		end else if (ts_in.valid) begin
			stage <= {stage[1:0], ts_in};
		end
	end

	// the oldest byte leaves the line when a new one comes in
	assign delayed = '{
		data: stage[2].data,
		sync: stage[2].sync,
		valid: stage[2].valid && ts_in.valid
	};

	assign pid_in = {stage[1].data[4:0], stage[0].data};
	assign pkt_start = delayed.valid && delayed.sync && delayed.data == TS_SYNC_BYTE;

	// scan downwards so the lowest matching slot is kept
	always_comb begin
		sel = '0;
		for (int s = PID_SLOTS - 1; s >= 0; s--) begin
			slot_hit[s] = match_enable && pid_table[s].match_en && pid_table[s].pid == pid_in;
			if (slot_hit[s]) begin
				sel = SLOT_W'(s);
			end
		end
	end

	assign match_info = '{
		hit: pkt_start && |slot_hit,
		slot: sel,
		change_pid: pid_table[sel].change_en,
		pts_en: pid_table[sel].pts_en,
		group: group_cnt[sel],
		pts: pts_table[sel]
	};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			group_cnt <= '0;
		end else if (match_info.hit) begin
			if (group_cnt[sel] == GROUP_W'(DATA_GROUPS - 1)) begin
				group_cnt[sel] <= '0;
			end else begin
				group_cnt[sel] <= group_cnt[sel] + GROUP_W'(1);
			end
		end
	end

	// the pid bytes belong to the packet that starts here
	a_hit_pid_in_packet: assert property (@(posedge clk) disable iff (!rst_n)
		match_info.hit |-> !stage[1].sync && !stage[0].sync);

endmodule

`default_nettype wire

//--- source/ts_packet_rewriter.sv
`default_nettype none

module ts_packet_rewriter import ts_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire ts_byte_t                delayed,
	input  wire match_info_t             match_info,
	output logic [WORD_ADDR_W-1:0]       rd_addr,
	input  wire logic [31:0]             rd_word,
	output ts_byte_t                     ts_out
);

	match_info_t info_q;
	logic [INDEX_W-1:0] k;
	logic [BYTE_ADDR_W-1:0] byte_addr;
	logic [7:0] r;
	logic [32:0] p;
	logic [PTS_BYTES-1:0][7:0] pts_bytes;
	logic [2:0] pts_idx;
	logic first_group;
	logic in_pts;
	logic [7:0] out_byte;
	logic [7:0] out_data;
	logic out_sync;
	logic out_valid;

	// byte k of group g sits at g*188 + k
	assign byte_addr = BYTE_ADDR_W'(info_q.group) * BYTE_ADDR_W'(PACK_BYTE_SIZE) +
		BYTE_ADDR_W'(k);
	assign rd_addr = byte_addr[BYTE_ADDR_W-1:2];
	assign r = rd_word[8 * byte_addr[1:0] +: 8];

	assign p = {1'b0, info_q.pts};
	assign pts_bytes[0] = {4'b0010, p[32:30], 1'b1};
	assign pts_bytes[1] = p[29:22];
	assign pts_bytes[2] = {p[21:15], 1'b1};
	assign pts_bytes[3] = p[14:7];
	assign pts_bytes[4] = {p[6:0], 1'b1};
	assign pts_idx = 3'(k - INDEX_W'(PTS_BYTE_FIRST));

	assign first_group = info_q.group == '0;
	assign in_pts = k >= INDEX_W'(PTS_BYTE_FIRST) && k < INDEX_W'(PTS_BYTE_FIRST + PTS_BYTES);

	always_comb begin
		out_byte = r;
		if (delayed.sync || !info_q.hit) begin
			out_byte = delayed.data;
		end else if (k == INDEX_W'(1)) begin
			// keep TEI and priority, PUSI only on the first group
			out_byte = {delayed.data[7], first_group, delayed.data[5],
				info_q.change_pid ? r[4:0] : delayed.data[4:0]};
		end else if (k == INDEX_W'(2)) begin
			out_byte = info_q.change_pid ? r : delayed.data;
		end else if (k == INDEX_W'(3)) begin
			// continuity counter stays from the input
			out_byte = {r[7:4], delayed.data[3:0]};
		end else if (in_pts && info_q.pts_en && first_group) begin
			out_byte = pts_bytes[pts_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			info_q <= '0;
			k <= '0;
		end else begin
			out_valid <= delayed.valid;
			if (delayed.valid) begin
				if (delayed.sync) begin
					info_q <= match_info;
					k <= INDEX_W'(1);
				end else begin
					k <= k + INDEX_W'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (delayed.valid) begin
			out_data <= out_byte;
			out_sync <= delayed.sync;
		end
	end

	assign ts_out = '{data: out_data, sync: out_sync, valid: out_valid};

	// packets never run past 188 bytes between syncs
	a_index_in_packet: assert property (@(posedge clk) disable iff (!rst_n)
		delayed.valid && !delayed.sync |-> k < INDEX_W'(PACK_BYTE_SIZE));

endmodule

`default_nettype wire

//--- source/ts_replacer_top.sv
`default_nettype none

module ts_replacer_top import ts_pkg::*, apb_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire apb_req_t apb_req,
	output apb_rsp_t      apb_rsp,
	input  wire ts_byte_t ts_in,
	output ts_byte_t      ts_out
);

	pid_entry_t [PID_SLOTS-1:0] pid_table;
	logic [PID_SLOTS-1:0][31:0] pts_table;
	logic match_enable;
	match_info_t match_info;
	ts_byte_t delayed;
	logic [WORD_ADDR_W-1:0] rd_addr;
	logic [31:0] rd_word;

	ts_replacer_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.pid_table    (pid_table),
		.pts_table    (pts_table),
		.match_enable (match_enable),
		.match_info   (match_info),
		.rd_addr      (rd_addr),
		.rd_word      (rd_word)
	);

	ts_pid_matcher u_matcher (
		.clk          (clk),
		.rst_n        (rst_n),
		.ts_in        (ts_in),
		.pid_table    (pid_table),
		.pts_table    (pts_table),
		.match_enable (match_enable),
		.match_info   (match_info),
		.delayed      (delayed)
	);

	ts_packet_rewriter u_rewriter (
		.clk        (clk),
		.rst_n      (rst_n),
		.delayed    (delayed),
		.match_info (match_info),
		.rd_addr    (rd_addr),
		.rd_word    (rd_word),
		.ts_out     (ts_out)
	);

endmodule

`default_nettype wire

//--- verif/tb_ts_replacer.sv
`default_nettype none

module tb_ts_replacer import ts_pkg::*, apb_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ROWS = 7;
	localparam int APB_LIMIT = 16;
	localparam int DRAIN_LIMIT = 64;

	// one row per scenario, slot is the slot expected to win
	typedef struct packed {
		logic [PID_W-1:0]  pkt_pid;
		logic [SLOT_W-1:0] slot;
		pid_entry_t        entry;
		logic              ctrl_en;
		logic [3:0]        packets;
		logic              exp_hit;
	} row_t;

	logic clk;
	logic rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	ts_byte_t ts_in;
	ts_byte_t ts_out;

	row_t rows [NUM_ROWS];
	logic [31:0] ram_model [DATA_WORDS];
	logic [31:0] pts_model [PID_SLOTS];
	int group_model [PID_SLOTS];
	int count_model;
	logic [7:0] pkt_buf [PACK_BYTE_SIZE];
	ts_byte_t exp_q [$];
	int out_count;

	ts_replacer_top UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.ts_in   (ts_in),
		.ts_out  (ts_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input ts_byte_t got, input ts_byte_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("[FAIL] t=%0t %s got data=%h sync=%b expected data=%h sync=%b",
				$time, name, got.data, got.sync, exp.data, exp.sync));
		end
	endtask

	task automatic check_word(input string name, input logic [APB_DATA_W-1:0] got,
		input logic [APB_DATA_W-1:0] exp);
		if (got !== exp) begin
			fail_stop($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_stop($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic apb_access(input logic [APB_ADDR_W-1:0] addr, input logic write,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		while (!apb_rsp.pready && waits < APB_LIMIT) begin
			@(posedge clk);
			@(negedge clk);
			waits++;
		end
		if (!apb_rsp.pready) begin
			fail_stop($sformatf("timeout: APB slave never raised pready at address %h", addr));
		end else begin
			rdata = apb_rsp.prdata;
			err = apb_rsp.pslverr;
			@(posedge clk);
			apb_req <= '0;
		end
	endtask

	task automatic reg_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		apb_access(addr, 1'b1, data, rdata, err);
		check_err($sformatf("pslverr write %h", addr), err, 1'b0);
	endtask

	task automatic reg_expect(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] exp);
		logic [31:0] rdata;
		logic err;
		apb_access(addr, 1'b0, 32'h0, rdata, err);
		check_err($sformatf("pslverr read %h", addr), err, 1'b0);
		check_word($sformatf("prdata %h", addr), rdata, exp);
	endtask

	function automatic logic [31:0] entry_word(input pid_entry_t e);
		logic [31:0] w;
		w = '0;
		w[PID_W-1:0] = e.pid;
		w[PID_MATCH_EN_BIT] = e.match_en;
		w[PID_CHANGE_EN_BIT] = e.change_en;
		w[PID_PTS_EN_BIT] = e.pts_en;
		return w;
	endfunction

	// PES style timestamp bytes with marker bits
	function automatic logic [7:0] pts_byte(input logic [31:0] pts, input int i);
		logic [32:0] p;
		logic [7:0] b;
		p = {1'b0, pts};
		case (i)
			0: b = {4'b0010, p[32:30], 1'b1};
			1: b = p[29:22];
			2: b = {p[21:15], 1'b1};
			3: b = p[14:7];
			default: b = {p[6:0], 1'b1};
		endcase
		return b;
	endfunction

	task automatic set_row(input int idx, input logic [PID_W-1:0] pkt_pid, input int slot,
		input logic pts_en, input logic change_en, input logic match_en,
		input logic [PID_W-1:0] entry_pid, input logic ctrl_en, input int packets,
		input logic exp_hit);
		rows[idx].pkt_pid = pkt_pid;
		rows[idx].slot = SLOT_W'(slot);
		rows[idx].entry = '{pts_en: pts_en, change_en: change_en, match_en: match_en,
			pid: entry_pid};
		rows[idx].ctrl_en = ctrl_en;
		rows[idx].packets = 4'(packets);
		rows[idx].exp_hit = exp_hit;
	endtask

	task automatic build_packet(input logic [PID_W-1:0] pid);
		pkt_buf[0] = TS_SYNC_BYTE;
		pkt_buf[1] = {3'($urandom), pid[12:8]};
		pkt_buf[2] = pid[7:0];
		for (int k = 3; k < PACK_BYTE_SIZE; k++) begin
			pkt_buf[k] = 8'($urandom);
		end
	endtask

	task automatic queue_expected(input logic hit, input int slot, input pid_entry_t e);
		int g;
		int a;
		logic [31:0] p;
		logic [7:0] r;
		logic [7:0] b;
		g = 0;
		p = '0;
		if (hit) begin
			g = group_model[slot];
			p = pts_model[slot];
			group_model[slot] = (g + 1) % DATA_GROUPS;
			pts_model[slot] = pts_model[slot] + PTS_STEP;
			count_model++;
		end
		for (int k = 0; k < PACK_BYTE_SIZE; k++) begin
			a = g * PACK_BYTE_SIZE + k;
			r = ram_model[a / 4][8 * (a % 4) +: 8];
			b = pkt_buf[k];
			if (hit && k == 1) begin
				b = {pkt_buf[1][7], g == 0, pkt_buf[1][5], e.change_en ? r[4:0] : pkt_buf[1][4:0]};
			end else if (hit && k == 2) begin
				b = e.change_en ? r : pkt_buf[2];
			end else if (hit && k == 3) begin
				b = {r[7:4], pkt_buf[3][3:0]};
			end else if (hit && k >= PTS_BYTE_FIRST && k < PTS_BYTE_FIRST + 5 && e.pts_en && g == 0) begin
				b = pts_byte(p, k - PTS_BYTE_FIRST);
			end else if (hit && k != 0) begin
				b = r;
			end
			exp_q.push_back('{data: b, sync: k == 0, valid: 1'b1});
		end
	endtask

	task automatic drive_packet();
		for (int k = 0; k < PACK_BYTE_SIZE; k++) begin
			@(posedge clk);
			ts_in <= '{data: pkt_buf[k], sync: k == 0, valid: 1'b1};
		end
	endtask

	always @(negedge clk) begin : monitor
		ts_byte_t e;
		if (rst_n && ts_out.valid) begin
			if (exp_q.size() == 0) begin
				fail_stop("byte appeared on ts_out when no byte was expected");
			end else begin
				e = exp_q.pop_front();
				check_byte($sformatf("ts_out[%0d]", out_count), ts_out, e);
				out_count++;
			end
		end
	end

	initial begin
		int cycles;
		logic [31:0] rdata;
		logic err;
		pid_entry_t e;
		apb_req = '0;
		ts_in = '0;
		rst_n = 1'b0;
		out_count = 0;
		count_model = 0;
		cycles = 0;
		void'($urandom(49));
		for (int s = 0; s < PID_SLOTS; s++) begin
			group_model[s] = 0;
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// register readback
		for (int s = 0; s < PID_SLOTS; s++) begin
			e = '{pts_en: 1'b1, change_en: 1'b1, match_en: 1'b1, pid: PID_W'($urandom)};
			reg_write(ADDR_PID_BASE + 16'(PID_STRIDE * s), entry_word(e));
			reg_expect(ADDR_PID_BASE + 16'(PID_STRIDE * s), entry_word(e));
			reg_write(ADDR_PID_BASE + 16'(PID_STRIDE * s), 32'h0);
			reg_expect(ADDR_PID_BASE + 16'(PID_STRIDE * s), 32'h0);
			pts_model[s] = $urandom;
			reg_write(ADDR_PID_BASE + 16'(PID_STRIDE * s + 4), pts_model[s]);
			reg_expect(ADDR_PID_BASE + 16'(PID_STRIDE * s + 4), pts_model[s]);
		end
		reg_write(ADDR_CTRL, 32'h1);
		reg_expect(ADDR_CTRL, 32'h1);
		reg_write(ADDR_CTRL, 32'h0);
		reg_expect(ADDR_CTRL, 32'h0);
		reg_expect(ADDR_COUNT, 32'h0);
		apb_access(16'h0050, 1'b0, 32'h0, rdata, err);
		check_err("pslverr unmapped read", err, 1'b1);
		apb_access(ADDR_COUNT, 1'b1, 32'h5, rdata, err);
		check_err("pslverr count write", err, 1'b1);

		for (int w = 0; w < DATA_WORDS; w++) begin
			ram_model[w] = $urandom;
			reg_write(ADDR_DATA_BASE + 16'(4 * w), ram_model[w]);
		end
		reg_expect(ADDR_DATA_BASE, ram_model[0]);
		reg_expect(ADDR_DATA_BASE + 16'(4 * (DATA_WORDS - 1)), ram_model[DATA_WORDS - 1]);

		// pkt pid, slot, pts, change, match, entry pid, ctrl, packets, hit
		set_row(0, 13'h0100, 0, 1'b0, 1'b0, 1'b1, 13'h0200, 1'b1, 1, 1'b0);
		set_row(1, 13'h0100, 0, 1'b0, 1'b0, 1'b1, 13'h0100, 1'b1, 1, 1'b1);
		set_row(2, 13'h0345, 1, 1'b0, 1'b1, 1'b1, 13'h0345, 1'b1, 1, 1'b1);
		set_row(3, 13'h0abc, 2, 1'b1, 1'b0, 1'b1, 13'h0abc, 1'b1, 3, 1'b1);
		set_row(4, 13'h1234, 3, 1'b1, 1'b1, 1'b1, 13'h1234, 1'b0, 2, 1'b0);
		set_row(5, 13'h0100, 0, 1'b0, 1'b0, 1'b0, 13'h0100, 1'b1, 1, 1'b0);
		// slot 1 and slot 2 both hold 0x0abc here
		set_row(6, 13'h0abc, 1, 1'b0, 1'b0, 1'b1, 13'h0abc, 1'b1, 2, 1'b1);

		for (int i = 0; i < NUM_ROWS; i++) begin
			reg_write(ADDR_CTRL, {31'b0, rows[i].ctrl_en});
			reg_write(ADDR_PID_BASE + 16'(PID_STRIDE * rows[i].slot), entry_word(rows[i].entry));
			for (int n = 0; n < rows[i].packets; n++) begin
				build_packet(rows[i].pkt_pid);
				queue_expected(rows[i].exp_hit, rows[i].slot, rows[i].entry);
				drive_packet();
			end
			@(posedge clk);
			ts_in <= '0;
			reg_expect(ADDR_COUNT, 32'(count_model));
			reg_expect(ADDR_PID_BASE + 16'(PID_STRIDE * rows[i].slot + 4), pts_model[rows[i].slot]);
		end

		// three bytes of a null packet push the last bytes out of the delay line
		build_packet(13'h1fff);
		for (int k = 0; k < 3; k++) begin
			@(posedge clk);
			ts_in <= '{data: pkt_buf[k], sync: k == 0, valid: 1'b1};
		end
		@(posedge clk);
		ts_in <= '0;
		while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			fail_stop($sformatf("timeout: %0d expected bytes never appeared on ts_out",
				exp_q.size()));
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
source/ts_pkg.sv
source/apb_pkg.sv
source/ts_replacer_regs.sv
source/ts_pid_matcher.sv
source/ts_packet_rewriter.sv
source/ts_replacer_top.sv
verif/tb_ts_replacer.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ts_replacer
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

SRCS = $(filter-out +%,$(shell cat $(FILELIST)))
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
